/* source/periph_pkg.sv */
package periph_pkg;

    // address and data width of every channel
    localparam int ADDR_W = 32;

    // address map, each device decodes DEV_SPAN bytes from its base
    localparam logic [ADDR_W-1:0] UART_BASE = 32'ha00003f8;
    localparam logic [ADDR_W-1:0] RTC_BASE  = 32'ha0000048;
    localparam int DEV_SPAN = 8;

    // serial line status register
    localparam int UART_LSR_OFF = 5;
    localparam logic [7:0] UART_LSR_IDLE = 8'h60;

    // clock cycles per counter tick
    localparam int RTC_DIV = 4;

    // response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   data;
        logic [ADDR_W/8-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [ADDR_W-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // target of a request, SEL_NONE for an unmapped address
    typedef enum logic [1:0] {SEL_UART, SEL_RTC, SEL_NONE} dev_sel_t;

endpackage

/* source/uart_sim_dev.sv */
`timescale 1ns/1ns

module uart_sim_dev import periph_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axi_ar_t    ar,
    input  logic       ar_valid,
    output logic       ar_ready,
    output axi_r_t     r,
    output logic       r_valid,
    input  logic       r_ready,
    input  axi_aw_t    aw,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  axi_w_t     w,
    input  logic       w_valid,
    output logic       w_ready,
    output axi_b_t     b,
    output logic       b_valid,
    input  logic       b_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    logic              ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic [ADDR_W-1:0] ar_off;
    logic [ADDR_W-1:0] wr_off;
    logic [ADDR_W-1:0] aw_addr_q;
    logic [ADDR_W-1:0] rd_data_q;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    assign ar_off = ar.addr - UART_BASE;
    assign wr_off = aw_addr_q - UART_BASE;

    // one read in flight, ready comes back after the response is taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end else if (ar_fire) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
        end else if (r_fire) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end
    end

    // no receive path, only the line status has content
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_data_q <= (ar_off == UART_LSR_OFF) ?
                         {{(ADDR_W-8){1'b0}}, UART_LSR_IDLE} : '0;
        end
    end

    assign r = '{data: rd_data_q, resp: RESP_OKAY};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_ready <= 1'b1;
            w_ready  <= 1'b1;
            b_valid  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_ready <= 1'b0;
            end else if (b_fire) begin
                aw_ready <= 1'b1;
            end
            if (w_fire) begin
                w_ready <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_fire) begin
                w_ready <= 1'b1;
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= aw.addr;
        end
        if (w_fire) begin
            tx_data <= w.data[7:0];
        end
    end

    // byte strobe lines up with the rising b_valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= w_fire && (wr_off == '0);
        end
    end

    assign b.resp = RESP_OKAY;

    // a new byte needs a fresh w transfer, which waits for the b handshake
    assert property (@(posedge clk) disable iff (rst) tx_valid |=> !tx_valid);

endmodule

/* source/rtc_dev.sv */
`timescale 1ns/1ns

module rtc_dev import periph_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready
);

    logic                       ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic [ADDR_W-1:0]          ar_off;
    logic [ADDR_W-1:0]          rd_data_q;
    logic [ADDR_W-1:0]          snap_hi;
    logic [$clog2(RTC_DIV)-1:0] presc;
    logic [2*ADDR_W-1:0]        cnt;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    assign ar_off = ar.addr - RTC_BASE;

    // prescaler wraps every RTC_DIV cycles and bumps the counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc <= '0;
            cnt   <= '0;
        end else if (presc == $bits(presc)'(RTC_DIV - 1)) begin
            presc <= '0;
            cnt   <= cnt + 1'b1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end else if (ar_fire) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
        end else if (r_fire) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end
    end

    // low word read freezes the high word for the following read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snap_hi <= '0;
        end else if (ar_fire && ar_off == 0) begin
            snap_hi <= cnt[2*ADDR_W-1:ADDR_W];
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            case (ar_off)
                0:       rd_data_q <= cnt[ADDR_W-1:0];
                4:       rd_data_q <= snap_hi;
                default: rd_data_q <= '0;
            endcase
        end
    end

    assign r = '{data: rd_data_q, resp: RESP_OKAY};

    // counter is read only, writes are accepted and refused
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_ready <= 1'b1;
            w_ready  <= 1'b1;
            b_valid  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_ready <= 1'b0;
            end else if (b_fire) begin
                aw_ready <= 1'b1;
            end
            if (w_fire) begin
                w_ready <= 1'b0;
                b_valid <= 1'b1;
            end else if (b_fire) begin
                w_ready <= 1'b1;
                b_valid <= 1'b0;
            end
        end
    end

    assign b.resp = RESP_SLVERR;

    assert property (@(posedge clk) disable iff (rst) cnt >= $past(cnt));

    // crossbar only routes addresses inside this span
    assert property (@(posedge clk) disable iff (rst)
        aw_valid |-> (aw.addr - RTC_BASE) < DEV_SPAN);

endmodule

/* source/periph_xbar.sv */
`timescale 1ns/1ns

module periph_xbar import periph_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,
    output axi_ar_t uart_ar,
    output logic    uart_ar_valid,
    input  logic    uart_ar_ready,
    input  axi_r_t  uart_r,
    input  logic    uart_r_valid,
    output logic    uart_r_ready,
    output axi_aw_t uart_aw,
    output logic    uart_aw_valid,
    input  logic    uart_aw_ready,
    output axi_w_t  uart_w,
    output logic    uart_w_valid,
    input  logic    uart_w_ready,
    input  axi_b_t  uart_b,
    input  logic    uart_b_valid,
    output logic    uart_b_ready,
    output axi_ar_t rtc_ar,
    output logic    rtc_ar_valid,
    input  logic    rtc_ar_ready,
    input  axi_r_t  rtc_r,
    input  logic    rtc_r_valid,
    output logic    rtc_r_ready,
    output axi_aw_t rtc_aw,
    output logic    rtc_aw_valid,
    input  logic    rtc_aw_ready,
    output axi_w_t  rtc_w,
    output logic    rtc_w_valid,
    input  logic    rtc_w_ready,
    input  axi_b_t  rtc_b,
    input  logic    rtc_b_valid,
    output logic    rtc_b_ready
);

    logic     ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic     rd_busy, wr_busy;
    logic     derr_r_valid, derr_b_valid;
    dev_sel_t ar_dec, aw_dec;
    dev_sel_t rd_sel, wr_sel;

    function automatic dev_sel_t decode(input logic [ADDR_W-1:0] addr);
        dev_sel_t sel;
        if ((addr - UART_BASE) < DEV_SPAN) begin
            sel = SEL_UART;
        end else if ((addr - RTC_BASE) < DEV_SPAN) begin
            sel = SEL_RTC;
        end else begin
            sel = SEL_NONE;
        end
        return sel;
    endfunction

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    assign ar_dec = decode(ar.addr);
    assign aw_dec = decode(aw.addr);

    // payloads fan out, only valid is steered
    assign uart_ar = ar;
    assign rtc_ar  = ar;
    assign uart_aw = aw;
    assign rtc_aw  = aw;
    assign uart_w  = w;
    assign rtc_w   = w;

    assign uart_ar_valid = ar_valid && !rd_busy && (ar_dec == SEL_UART);
    assign rtc_ar_valid  = ar_valid && !rd_busy && (ar_dec == SEL_RTC);
    assign uart_aw_valid = aw_valid && !wr_busy && (aw_dec == SEL_UART);
    assign rtc_aw_valid  = aw_valid && !wr_busy && (aw_dec == SEL_RTC);
    assign uart_w_valid  = w_valid && wr_busy && (wr_sel == SEL_UART);
    assign rtc_w_valid   = w_valid && wr_busy && (wr_sel == SEL_RTC);

    assign uart_r_ready = r_ready && (rd_sel == SEL_UART);
    assign rtc_r_ready  = r_ready && (rd_sel == SEL_RTC);
    assign uart_b_ready = b_ready && (wr_sel == SEL_UART);
    assign rtc_b_ready  = b_ready && (wr_sel == SEL_RTC);

    // address ready follows the decoded target, unmapped is taken here
    always_comb begin
        case (ar_dec)
            SEL_UART: ar_ready = !rd_busy && uart_ar_ready;
            SEL_RTC:  ar_ready = !rd_busy && rtc_ar_ready;
            default:  ar_ready = !rd_busy;
        endcase
        case (aw_dec)
            SEL_UART: aw_ready = !wr_busy && uart_aw_ready;
            SEL_RTC:  aw_ready = !wr_busy && rtc_aw_ready;
            default:  aw_ready = !wr_busy;
        endcase
    end

    always_comb begin
        case (rd_sel)
            SEL_UART: begin
                r       = uart_r;
                r_valid = uart_r_valid;
            end
            SEL_RTC: begin
                r       = rtc_r;
                r_valid = rtc_r_valid;
            end
            default: begin
                r       = '{data: '0, resp: RESP_DECERR};
                r_valid = derr_r_valid;
            end
        endcase
    end

    always_comb begin
        case (wr_sel)
            SEL_UART: begin
                w_ready = wr_busy && uart_w_ready;
                b       = uart_b;
                b_valid = uart_b_valid;
            end
            SEL_RTC: begin
                w_ready = wr_busy && rtc_w_ready;
                b       = rtc_b;
                b_valid = rtc_b_valid;
            end
            default: begin
                w_ready = wr_busy && !derr_b_valid;
                b       = '{resp: RESP_DECERR};
                b_valid = derr_b_valid;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_busy      <= 1'b0;
            rd_sel       <= SEL_NONE;
            derr_r_valid <= 1'b0;
        end else if (ar_fire) begin
            rd_busy      <= 1'b1;
            rd_sel       <= ar_dec;
            derr_r_valid <= (ar_dec == SEL_NONE);
        end else if (r_fire) begin
            rd_busy      <= 1'b0;
            derr_r_valid <= 1'b0;
        end
    end

    // write stays open from aw transfer until b transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_busy      <= 1'b0;
            wr_sel       <= SEL_NONE;
            derr_b_valid <= 1'b0;
        end else begin
            if (aw_fire) begin
                wr_busy <= 1'b1;
                wr_sel  <= aw_dec;
            end else if (b_fire) begin
                wr_busy <= 1'b0;
            end
            if (w_fire && wr_sel == SEL_NONE) begin
                derr_b_valid <= 1'b1;
            end else if (b_fire) begin
                derr_b_valid <= 1'b0;
            end
        end
    end

    // responses from either device or the decode error path hold until taken
    assert property (@(posedge clk) disable iff (rst)
        r_valid && !r_ready |=> r_valid && $stable(r));
    assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

/* source/periph_top.sv */
`timescale 1ns/1ns

module periph_top import periph_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axi_ar_t    ar,
    input  logic       ar_valid,
    output logic       ar_ready,
    output axi_r_t     r,
    output logic       r_valid,
    input  logic       r_ready,
    input  axi_aw_t    aw,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  axi_w_t     w,
    input  logic       w_valid,
    output logic       w_ready,
    output axi_b_t     b,
    output logic       b_valid,
    input  logic       b_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    // one downstream channel set per device
    axi_ar_t uart_ar, rtc_ar;
    axi_r_t  uart_r, rtc_r;
    axi_aw_t uart_aw, rtc_aw;
    axi_w_t  uart_w, rtc_w;
    axi_b_t  uart_b, rtc_b;
    logic    uart_ar_valid, uart_ar_ready, rtc_ar_valid, rtc_ar_ready;
    logic    uart_r_valid, uart_r_ready, rtc_r_valid, rtc_r_ready;
    logic    uart_aw_valid, uart_aw_ready, rtc_aw_valid, rtc_aw_ready;
    logic    uart_w_valid, uart_w_ready, rtc_w_valid, rtc_w_ready;
    logic    uart_b_valid, uart_b_ready, rtc_b_valid, rtc_b_ready;

    periph_xbar periph_xbar_i (.*);

    uart_sim_dev uart_sim_dev_i (
        .clk(clk), .rst(rst),
        .ar(uart_ar), .ar_valid(uart_ar_valid), .ar_ready(uart_ar_ready),
        .r(uart_r), .r_valid(uart_r_valid), .r_ready(uart_r_ready),
        .aw(uart_aw), .aw_valid(uart_aw_valid), .aw_ready(uart_aw_ready),
        .w(uart_w), .w_valid(uart_w_valid), .w_ready(uart_w_ready),
        .b(uart_b), .b_valid(uart_b_valid), .b_ready(uart_b_ready),
        .tx_data(tx_data), .tx_valid(tx_valid)
    );

    rtc_dev rtc_dev_i (
        .clk(clk), .rst(rst),
        .ar(rtc_ar), .ar_valid(rtc_ar_valid), .ar_ready(rtc_ar_ready),
        .r(rtc_r), .r_valid(rtc_r_valid), .r_ready(rtc_r_ready),
        .aw(rtc_aw), .aw_valid(rtc_aw_valid), .aw_ready(rtc_aw_ready),
        .w(rtc_w), .w_valid(rtc_w_valid), .w_ready(rtc_w_ready),
        .b(rtc_b), .b_valid(rtc_b_valid), .b_ready(rtc_b_ready)
    );

endmodule

/* tb/periph_tb.sv */
`timescale 1ns/1ns

module periph_tb import periph_pkg::*; ();

    localparam int N_OPS = 200;
    localparam int WATCHDOG_CYCLES = N_OPS * 40;

    logic        clk;
    logic        rst;
    axi_ar_t     ar;
    logic        ar_valid, ar_ready;
    axi_r_t      r;
    logic        r_valid, r_ready;
    axi_aw_t     aw;
    logic        aw_valid, aw_ready;
    axi_w_t      w;
    logic        w_valid, w_ready;
    axi_b_t      b;
    logic        b_valid, b_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;

    logic [31:0] rng_state;
    logic [7:0]  tx_q[$];
    int          cyc;

    periph_top periph_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycles since reset release for the counter step bound
    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ready low about one cycle in four
    function automatic logic rand_ready();
        return (next_rand() % 4) != 0;
    endfunction

    function automatic dev_sel_t target_of(input logic [31:0] addr);
        if (addr >= UART_BASE && addr < UART_BASE + DEV_SPAN) begin
            return SEL_UART;
        end
        if (addr >= RTC_BASE && addr < RTC_BASE + DEV_SPAN) begin
            return SEL_RTC;
        end
        return SEL_NONE;
    endfunction

    // random word or a near miss just outside a device span
    function automatic logic [31:0] pick_unmapped();
        logic [31:0] addr;
        do begin
            case (next_rand() % 3)
                0:       addr = next_rand();
                1:       addr = UART_BASE + DEV_SPAN + (next_rand() % 8);
                default: addr = RTC_BASE - 1 - (next_rand() % 8);
            endcase
        end while (target_of(addr) != SEL_NONE);
        return addr;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string msg);
        $display("%0t ns %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic read_txn(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, output int hs_cycle);
        axi_r_t held;
        @(posedge clk);
        #1;
        ar.addr  = addr;
        ar_valid = 1'b1;
        r_ready  = rand_ready();
        @(negedge clk);
        while (!ar_ready) begin
            @(posedge clk);
            #1;
            @(negedge clk);
        end
        hs_cycle = cyc;
        @(posedge clk);
        #1;
        ar_valid = 1'b0;
        r_ready  = rand_ready();
        @(negedge clk);
        check("r_valid", 1, r_valid);
        check("ar_ready", 0, ar_ready);
        held = r;
        // response must hold while the master stalls
        while (!r_ready) begin
            @(posedge clk);
            #1;
            r_ready = rand_ready();
            @(negedge clk);
            check("r_valid", 1, r_valid);
            check("r", held, r);
            check("ar_ready", 0, ar_ready);
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk);
        #1;
        r_ready = rand_ready();
        @(negedge clk);
        check("r_valid", 0, r_valid);
        check("ar_ready", 1, ar_ready);
    endtask

    task automatic write_txn(input logic [31:0] addr, input axi_w_t wd,
                             input logic strobe, output logic [1:0] resp);
        axi_b_t held;
        int     gap;
        gap = next_rand() % 3;
        @(posedge clk);
        #1;
        aw.addr  = addr;
        aw_valid = 1'b1;
        b_ready  = rand_ready();
        @(negedge clk);
        while (!aw_ready) begin
            @(posedge clk);
            #1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        aw_valid = 1'b0;
        b_ready  = rand_ready();
        repeat (gap) begin
            @(negedge clk);
            check("w_ready", 1, w_ready);
            check("b_valid", 0, b_valid);
            check("aw_ready", 0, aw_ready);
            @(posedge clk);
            #1;
            b_ready = rand_ready();
        end
        if (strobe) begin
            tx_q.push_back(wd.data[7:0]);
        end
        w       = wd;
        w_valid = 1'b1;
        @(negedge clk);
        check("w_ready", 1, w_ready);
        check("aw_ready", 0, aw_ready);
        @(posedge clk);
        #1;
        w_valid = 1'b0;
        b_ready = rand_ready();
        @(negedge clk);
        check("b_valid", 1, b_valid);
        check("tx_valid", strobe, tx_valid);
        check("aw_ready", 0, aw_ready);
        held = b;
        while (!b_ready) begin
            @(posedge clk);
            #1;
            b_ready = rand_ready();
            @(negedge clk);
            check("b_valid", 1, b_valid);
            check("b", held, b);
            check("aw_ready", 0, aw_ready);
        end
        resp = b.resp;
        @(posedge clk);
        #1;
        b_ready = rand_ready();
        @(negedge clk);
        check("b_valid", 0, b_valid);
        check("aw_ready", 1, aw_ready);
    endtask

    // every strobe must match the oldest byte still expected
    always @(negedge clk) begin
        if (!rst && tx_valid) begin
            if (tx_q.size() == 0) begin
                report_error($sformatf("tx strobe with data %h but no byte was expected",
                                       tx_data));
            end else begin
                check("tx_data", tx_q[0], tx_data);
                void'(tx_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 10) @(posedge clk);
        $display("timeout after %0d cycles, the operations did not all complete",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] lo, hi;
        logic [1:0]  resp;
        logic [63:0] rtc_val, prev_val;
        int          lo_cyc, prev_cyc, unused_cyc;
        int          off;
        axi_w_t      wd;
        ar        = '0;
        ar_valid  = 1'b0;
        r_ready   = 1'b0;
        aw        = '0;
        aw_valid  = 1'b0;
        w         = '0;
        w_valid   = 1'b0;
        b_ready   = 1'b0;
        rst       = 1'b1;
        rng_state = 32'h50848a4d;
        prev_val  = '0;
        prev_cyc  = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < N_OPS; i++) begin
            wd.data = next_rand();
            wd.strb = next_rand();
            off     = next_rand() % DEV_SPAN;
            case (next_rand() % 8)
                0, 1: begin
                    write_txn(UART_BASE, wd, 1'b1, resp);
                    check("b.resp", RESP_OKAY, resp);
                end
                2: begin
                    write_txn(UART_BASE + off, wd, off == 0, resp);
                    check("b.resp", RESP_OKAY, resp);
                end
                3: begin
                    read_txn(UART_BASE + off, data, resp, unused_cyc);
                    check("r.resp", RESP_OKAY, resp);
                    check("r.data", (off == UART_LSR_OFF) ? UART_LSR_IDLE : 0, data);
                end
                4: begin
                    read_txn(RTC_BASE, lo, resp, lo_cyc);
                    check("r.resp", RESP_OKAY, resp);
                    read_txn(RTC_BASE + 4, hi, resp, unused_cyc);
                    check("r.resp", RESP_OKAY, resp);
                    rtc_val = {hi, lo};
                    if (rtc_val < prev_val) begin
                        report_error($sformatf("counter went back from %h to %h",
                                               prev_val, rtc_val));
                    end
                    if (rtc_val - prev_val > (lo_cyc - prev_cyc) / RTC_DIV + 1) begin
                        report_error($sformatf("counter moved from %h to %h in %0d cycles",
                                               prev_val, rtc_val, lo_cyc - prev_cyc));
                    end
                    prev_val = rtc_val;
                    prev_cyc = lo_cyc;
                end
                5: begin
                    write_txn(RTC_BASE + off, wd, 1'b0, resp);
                    check("b.resp", RESP_SLVERR, resp);
                end
                6: begin
                    addr = pick_unmapped();
                    read_txn(addr, data, resp, unused_cyc);
                    check("r.resp", RESP_DECERR, resp);
                    check("r.data", 0, data);
                end
                default: begin
                    addr = pick_unmapped();
                    write_txn(addr, wd, 1'b0, resp);
                    check("b.resp", RESP_DECERR, resp);
                end
            endcase
        end
        repeat (4) @(posedge clk);
        check("tx_bytes_outstanding", 0, tx_q.size());
        $display("No errors");
        $finish;
    end

endmodule

/* build.f */
source/periph_pkg.sv
source/uart_sim_dev.sv
source/rtc_dev.sv
source/periph_xbar.sv
source/periph_top.sv
tb/periph_tb.sv

/* Bender.yml */
package:
  name: periph

sources:
  - source/periph_pkg.sv
  - source/uart_sim_dev.sv
  - source/rtc_dev.sv
  - source/periph_xbar.sv
  - source/periph_top.sv
  - target: test
    files:
      - tb/periph_tb.sv
